// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // fetch packet shape
    localparam int unsigned NUM_SLOTS = 2;
    localparam int unsigned XLEN      = 32; // data and pc width
    localparam int unsigned INST_W    = 32;

    // decoded packet shape
    localparam int unsigned SRCS_PER_SLOT = 2;
    localparam int unsigned NUM_SRCS      = NUM_SLOTS * SRCS_PER_SLOT;
    localparam int unsigned ARF_ID_W      = 5;

    // one bit per slot, mask and write flags
    typedef logic [NUM_SLOTS-1:0] slot_flag_t;

    // one word per slot, pc and immediates
    typedef logic [NUM_SLOTS-1:0][XLEN-1:0] slot_word_t;

    typedef logic [NUM_SLOTS-1:0][INST_W-1:0] slot_inst_t;

    // per read operand, slot i owns entries 2i and 2i+1
    typedef logic [NUM_SRCS-1:0] src_flag_t;
    typedef logic [NUM_SRCS-1:0][ARF_ID_W-1:0] src_arfid_t;

    typedef logic [NUM_SLOTS-1:0][ARF_ID_W-1:0] dst_arfid_t;

endpackage

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // read operand source, none reads r0
    typedef enum logic [2:0] {
        REG_NONE = 3'd0,
        REG_RD   = 3'd1,
        REG_RJ   = 3'd2,
        REG_RK   = 3'd3,
        REG_IMM  = 3'd4
    } reg_src_e;

    typedef enum logic [1:0] {
        DST_NONE = 2'd0,
        DST_RD   = 2'd1,
        DST_R1   = 2'd2  // link register, BL only
    } reg_dst_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_SI12 = 2'd1,
        IMM_UI12 = 2'd2,
        IMM_SI20 = 2'd3  // already shifted left by 12
    } imm_type_e;

    typedef enum logic [1:0] {
        AIMM_NONE   = 2'd0,
        AIMM_SI12   = 2'd1, // load/store offset
        AIMM_OFFS16 = 2'd2, // beq, << 2
        AIMM_OFFS26 = 2'd3  // bl, << 2
    } addr_imm_type_e;

    typedef enum logic [2:0] {
        UNIT_INVALID = 3'd0,
        UNIT_ALU     = 3'd1,
        UNIT_MDU     = 3'd2,
        UNIT_LSU     = 3'd3,
        UNIT_BRU     = 3'd4
    } unit_e;

    typedef struct packed {
        unit_e          unit;
        logic           inst_valid;
        reg_src_e       src0;
        reg_src_e       src1;
        reg_dst_e       dst;
        imm_type_e      imm_type;
        addr_imm_type_e addr_imm_type;
        logic           mem_write;
    } decode_info_t;

    // register field positions in the instruction word
    localparam int unsigned RD_LSB = 0;
    localparam int unsigned RJ_LSB = 5;
    localparam int unsigned RK_LSB = 10;
    localparam int unsigned LINK_ARF_ID = 1;

    // 3R format, matched on ins[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002A;
    localparam logic [16:0] OP_MUL_W = 17'h00038;
    localparam logic [16:0] OP_DIV_W = 17'h00040;
    // 2RI12 format, matched on ins[31:22]
    localparam logic [9:0]  OP_ADDI_W = 10'h00A;
    localparam logic [9:0]  OP_ORI    = 10'h00E;
    localparam logic [9:0]  OP_LD_W   = 10'h0A2;
    localparam logic [9:0]  OP_ST_W   = 10'h0A6;
    // 1RI20, ins[31:25]
    localparam logic [6:0]  OP_LU12I_W = 7'h0A;
    // branches, ins[31:26]
    localparam logic [5:0]  OP_BEQ = 6'h16;
    localparam logic [5:0]  OP_BL  = 6'h15;

endpackage

`default_nettype wire

// ==== source/fetch_bundle_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// packet held in the stage register
interface fetch_bundle_if;

    logic                 valid;
    pipe_pkg::slot_flag_t mask;
    pipe_pkg::slot_word_t pc;
    pipe_pkg::slot_inst_t inst;

    // driven by the stage register
    modport held (output valid, mask, pc, inst);

    // read side
    modport view (input valid, mask, pc, inst);

endinterface

`default_nettype wire

// ==== source/decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 in_valid_i,
    input  pipe_pkg::slot_flag_t in_mask_i,
    input  pipe_pkg::slot_word_t in_pc_i,
    input  pipe_pkg::slot_inst_t in_inst_i,
    output logic                 in_ready_o,
    input  logic                 out_ready_i,
    fetch_bundle_if.held         held
);

    logic                 valid_q;
    logic                 in_fire;
    pipe_pkg::slot_flag_t mask_q;
    pipe_pkg::slot_word_t pc_q;
    pipe_pkg::slot_inst_t inst_q;

    // empty or draining this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            mask_q  <= '0;
        end else if (in_fire) begin
            valid_q <= 1'b1; // refill, possibly on the same edge as the drain
            mask_q  <= in_mask_i;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            pc_q   <= in_pc_i;
            inst_q <= in_inst_i;
        end
    end

    assign held.valid = valid_q;
    assign held.mask  = mask_q;
    assign held.pc    = pc_q;
    assign held.inst  = inst_q;

endmodule

`default_nettype wire

// ==== source/basic_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module basic_decoder (
    input  logic [31:0]          ins_i,
    output isa_pkg::decode_info_t decode_info_o
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    assign op17 = ins_i[31:15];
    assign op10 = ins_i[31:22];
    assign op7  = ins_i[31:25];
    assign op6  = ins_i[31:26];

    always_comb begin
        // unknown encodings fall through with everything cleared
        decode_info_o.unit          = isa_pkg::UNIT_INVALID;
        decode_info_o.inst_valid    = 1'b0;
        decode_info_o.src0          = isa_pkg::REG_NONE;
        decode_info_o.src1          = isa_pkg::REG_NONE;
        decode_info_o.dst           = isa_pkg::DST_NONE;
        decode_info_o.imm_type      = isa_pkg::IMM_NONE;
        decode_info_o.addr_imm_type = isa_pkg::AIMM_NONE;
        decode_info_o.mem_write     = 1'b0;

        if (op17 == isa_pkg::OP_ADD_W || op17 == isa_pkg::OP_SUB_W ||
            op17 == isa_pkg::OP_SLT   || op17 == isa_pkg::OP_AND   ||
            op17 == isa_pkg::OP_OR) begin
            decode_info_o.unit       = isa_pkg::UNIT_ALU;
            decode_info_o.inst_valid = 1'b1;
            decode_info_o.src0       = isa_pkg::REG_RJ;
            decode_info_o.src1       = isa_pkg::REG_RK;
            decode_info_o.dst        = isa_pkg::DST_RD;
        end else if (op17 == isa_pkg::OP_MUL_W || op17 == isa_pkg::OP_DIV_W) begin
            decode_info_o.unit       = isa_pkg::UNIT_MDU; // same operands as 3R alu
            decode_info_o.inst_valid = 1'b1;
            decode_info_o.src0       = isa_pkg::REG_RJ;
            decode_info_o.src1       = isa_pkg::REG_RK;
            decode_info_o.dst        = isa_pkg::DST_RD;
        end else if (op10 == isa_pkg::OP_ADDI_W || op10 == isa_pkg::OP_ORI) begin
            decode_info_o.unit       = isa_pkg::UNIT_ALU;
            decode_info_o.inst_valid = 1'b1;
            decode_info_o.src0       = isa_pkg::REG_RJ;
            decode_info_o.src1       = isa_pkg::REG_IMM;
            decode_info_o.dst        = isa_pkg::DST_RD;
            // ori takes a zero-extended immediate
            decode_info_o.imm_type   = (op10 == isa_pkg::OP_ORI) ?
                                       isa_pkg::IMM_UI12 : isa_pkg::IMM_SI12;
        end else if (op10 == isa_pkg::OP_LD_W) begin
            decode_info_o.unit          = isa_pkg::UNIT_LSU;
            decode_info_o.inst_valid    = 1'b1;
            decode_info_o.src0          = isa_pkg::REG_RJ; // base
            decode_info_o.dst           = isa_pkg::DST_RD;
            decode_info_o.addr_imm_type = isa_pkg::AIMM_SI12;
        end else if (op10 == isa_pkg::OP_ST_W) begin
            decode_info_o.unit          = isa_pkg::UNIT_LSU;
            decode_info_o.inst_valid    = 1'b1;
            decode_info_o.src0          = isa_pkg::REG_RJ;
            decode_info_o.src1          = isa_pkg::REG_RD; // store data
            decode_info_o.addr_imm_type = isa_pkg::AIMM_SI12;
            decode_info_o.mem_write     = 1'b1;
        end else if (op7 == isa_pkg::OP_LU12I_W) begin
            decode_info_o.unit       = isa_pkg::UNIT_ALU;
            decode_info_o.inst_valid = 1'b1;
            decode_info_o.src1       = isa_pkg::REG_IMM;
            decode_info_o.dst        = isa_pkg::DST_RD;
            decode_info_o.imm_type   = isa_pkg::IMM_SI20;
        end else if (op6 == isa_pkg::OP_BEQ) begin
            decode_info_o.unit          = isa_pkg::UNIT_BRU;
            decode_info_o.inst_valid    = 1'b1;
            decode_info_o.src0          = isa_pkg::REG_RJ;
            decode_info_o.src1          = isa_pkg::REG_RD; // compared, not written
            decode_info_o.addr_imm_type = isa_pkg::AIMM_OFFS16;
        end else if (op6 == isa_pkg::OP_BL) begin
            decode_info_o.unit          = isa_pkg::UNIT_BRU;
            decode_info_o.inst_valid    = 1'b1;
            decode_info_o.dst           = isa_pkg::DST_R1;
            decode_info_o.addr_imm_type = isa_pkg::AIMM_OFFS26;
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  isa_pkg::decode_info_t [pipe_pkg::NUM_SLOTS-1:0] info_i,
    input  pipe_pkg::slot_inst_t                           inst_i,
    output pipe_pkg::src_arfid_t                           r_arfid_o,
    output pipe_pkg::src_flag_t                            reg_need_o,
    output pipe_pkg::src_flag_t                            use_imm_o,
    output pipe_pkg::dst_arfid_t                           w_arfid_o,
    output pipe_pkg::slot_flag_t                           w_reg_o,
    output pipe_pkg::slot_flag_t                           w_mem_o
);

    // read operands, two per slot
    for (genvar k = 0; k < pipe_pkg::NUM_SRCS; k++) begin : g_src
        localparam int unsigned SLOT = k / pipe_pkg::SRCS_PER_SLOT;
        isa_pkg::reg_src_e               src;
        logic [pipe_pkg::INST_W-1:0]     word;
        logic [pipe_pkg::ARF_ID_W-1:0]   id;

        assign word = inst_i[SLOT];
        assign src  = (k % pipe_pkg::SRCS_PER_SLOT == 0) ? info_i[SLOT].src0 : info_i[SLOT].src1;

        always_comb begin
            case (src)
                isa_pkg::REG_RD: id = word[isa_pkg::RD_LSB +: pipe_pkg::ARF_ID_W];
                isa_pkg::REG_RJ: id = word[isa_pkg::RJ_LSB +: pipe_pkg::ARF_ID_W];
                isa_pkg::REG_RK: id = word[isa_pkg::RK_LSB +: pipe_pkg::ARF_ID_W];
                default:         id = '0; // none and imm both read r0
            endcase
        end

        assign r_arfid_o[k]  = id;
        assign reg_need_o[k] = (src == isa_pkg::REG_RD) || (src == isa_pkg::REG_RJ) ||
                               (src == isa_pkg::REG_RK);
        assign use_imm_o[k]  = (src == isa_pkg::REG_IMM);
    end

    // destination per slot
    for (genvar i = 0; i < pipe_pkg::NUM_SLOTS; i++) begin : g_dst
        logic [pipe_pkg::ARF_ID_W-1:0] id;

        always_comb begin
            case (info_i[i].dst)
                isa_pkg::DST_RD: id = inst_i[i][isa_pkg::RD_LSB +: pipe_pkg::ARF_ID_W];
                isa_pkg::DST_R1: id = pipe_pkg::ARF_ID_W'(isa_pkg::LINK_ARF_ID);
                default:         id = '0;
            endcase
        end

        assign w_arfid_o[i] = id;
        assign w_reg_o[i]   = (info_i[i].dst != isa_pkg::DST_NONE);
        assign w_mem_o[i]   = info_i[i].mem_write;
    end

endmodule

`default_nettype wire

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  isa_pkg::decode_info_t [pipe_pkg::NUM_SLOTS-1:0] info_i,
    input  pipe_pkg::slot_inst_t                           inst_i,
    output pipe_pkg::slot_word_t                           data_imm_o,
    output pipe_pkg::slot_word_t                           addr_imm_o
);

    for (genvar i = 0; i < pipe_pkg::NUM_SLOTS; i++) begin : g_slot
        logic [pipe_pkg::INST_W-1:0] ins;
        logic [pipe_pkg::XLEN-1:0]   data_imm;
        logic [pipe_pkg::XLEN-1:0]   addr_imm;

        assign ins = inst_i[i];

        always_comb begin
            case (info_i[i].imm_type)
                isa_pkg::IMM_SI12: data_imm = {{20{ins[21]}}, ins[21:10]};
                isa_pkg::IMM_UI12: data_imm = {20'd0, ins[21:10]};
                isa_pkg::IMM_SI20: data_imm = {ins[24:5], 12'd0}; // lu12i
                default:           data_imm = '0;
            endcase

            case (info_i[i].addr_imm_type)
                isa_pkg::AIMM_SI12:   addr_imm = {{20{ins[21]}}, ins[21:10]};
                isa_pkg::AIMM_OFFS16: addr_imm = {{14{ins[25]}}, ins[25:10], 2'b00};
                // offs26 keeps its high part in the low bits of the word
                isa_pkg::AIMM_OFFS26: addr_imm = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
                default:              addr_imm = '0;
            endcase
        end

        assign data_imm_o[i] = data_imm;
        assign addr_imm_o[i] = addr_imm;
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    // fetch side
    input  logic                                    in_valid_i,
    input  pipe_pkg::slot_flag_t                    in_mask_i,
    input  pipe_pkg::slot_word_t                    in_pc_i,
    input  pipe_pkg::slot_inst_t                    in_inst_i,
    output logic                                    in_ready_o,
    // rename side
    output logic                                    out_valid_o,
    input  logic                                    out_ready_i,
    output pipe_pkg::slot_flag_t                    slot_valid_o,
    output pipe_pkg::slot_word_t                    pc_o,
    output isa_pkg::unit_e [pipe_pkg::NUM_SLOTS-1:0] unit_o,
    output pipe_pkg::slot_flag_t                    w_reg_o,
    output pipe_pkg::slot_flag_t                    w_mem_o,
    output pipe_pkg::src_flag_t                     reg_need_o,
    output pipe_pkg::src_flag_t                     use_imm_o,
    output pipe_pkg::src_arfid_t                    r_arfid_o,
    output pipe_pkg::dst_arfid_t                    w_arfid_o,
    output pipe_pkg::slot_word_t                    data_imm_o,
    output pipe_pkg::slot_word_t                    addr_imm_o
);

    fetch_bundle_if bundle ();

    isa_pkg::decode_info_t [pipe_pkg::NUM_SLOTS-1:0] info;

    decode_ctrl u_ctrl (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_mask_i   (in_mask_i),
        .in_pc_i     (in_pc_i),
        .in_inst_i   (in_inst_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .held        (bundle.held)
    );

    // one decoder per slot, masked slots decode too
    for (genvar i = 0; i < pipe_pkg::NUM_SLOTS; i++) begin : g_dec
        basic_decoder u_dec (
            .ins_i         (bundle.inst[i]),
            .decode_info_o (info[i])
        );
        assign unit_o[i] = info[i].unit;
    end

    operand_select u_opsel (
        .info_i     (info),
        .inst_i     (bundle.inst),
        .r_arfid_o  (r_arfid_o),
        .reg_need_o (reg_need_o),
        .use_imm_o  (use_imm_o),
        .w_arfid_o  (w_arfid_o),
        .w_reg_o    (w_reg_o),
        .w_mem_o    (w_mem_o)
    );

    imm_gen u_imm (
        .info_i     (info),
        .inst_i     (bundle.inst),
        .data_imm_o (data_imm_o),
        .addr_imm_o (addr_imm_o)
    );

    assign out_valid_o  = bundle.valid;
    assign slot_valid_o = bundle.mask;
    assign pc_o         = bundle.pc;

endmodule

`default_nettype wire

// ==== sim/decode_stage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 valid_q,
    input logic                 in_ready_o,
    input logic                 out_ready_i,
    input pipe_pkg::slot_flag_t mask_q,
    input pipe_pkg::slot_word_t pc_q,
    input pipe_pkg::slot_inst_t inst_q
);

    // empty the cycle after reset
    a_reset_empty: assert property (@(posedge clk_i) reset_i |=> !valid_q)
        else $error("stage holds a packet right after reset");

    a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_q && !out_ready_i) |=> (valid_q && $stable(mask_q) && $stable(pc_q)
                                       && $stable(inst_q)))
        else $error("held packet changed while stalled");

    // full and blocked means no new input
    a_full_not_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_q && !out_ready_i) |-> !in_ready_o)
        else $error("in_ready_o high while full and stalled");

endmodule

bind decode_ctrl decode_stage_chk u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_q     (valid_q),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .mask_q      (mask_q),
    .pc_q        (pc_q),
    .inst_q      (inst_q)
);

`default_nettype wire

// ==== sim/decode_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_monitor (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        out_valid_i,
    input  logic        out_ready_i,
    input  logic        in_ready_i,
    input  logic [1:0]  slot_valid_i,
    input  logic [63:0] pc_i,
    input  logic [5:0]  unit_i,
    input  logic [1:0]  w_reg_i,
    input  logic [1:0]  w_mem_i,
    input  logic [3:0]  reg_need_i,
    input  logic [3:0]  use_imm_i,
    input  logic [19:0] r_arfid_i,
    input  logic [9:0]  w_arfid_i,
    input  logic [63:0] data_imm_i,
    input  logic [63:0] addr_imm_i,
    input  int          n_vec_i,
    input  logic [1:0]  exp_slot_valid_i,
    input  logic [63:0] exp_pc_i,
    input  logic [5:0]  exp_unit_i,
    input  logic [1:0]  exp_w_reg_i,
    input  logic [1:0]  exp_w_mem_i,
    input  logic [3:0]  exp_need_i,
    input  logic [3:0]  exp_use_i,
    input  logic [19:0] exp_r_arfid_i,
    input  logic [9:0]  exp_w_arfid_i,
    input  logic [63:0] exp_data_imm_i,
    input  logic [63:0] exp_addr_imm_i,
    output int          cnt_o,
    output int          fail_o
);

    logic [241:0] cur;
    logic [241:0] snap;
    logic         stalled;
    logic         fresh;   // first cycle out of reset

    assign cur = {slot_valid_i, pc_i, unit_i, w_reg_i, w_mem_i, reg_need_i, use_imm_i,
                  r_arfid_i, w_arfid_i, data_imm_i, addr_imm_i};

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act, inout bit bad);
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            bad = 1'b1;
        end
    endtask

    // stage must come out of reset empty and ready
    task automatic check_reset();
        bit bad;
        bad = 1'b0;
        check_field("out_valid_o", 64'(1'b0), 64'(out_valid_i), bad);
        check_field("in_ready_o",  64'(1'b1), 64'(in_ready_i),  bad);
        if (bad) begin
            $display("FAIL reset check at t=%0t", $time);
            fail_o <= fail_o + 1;
        end else begin
            $display("PASS reset check at t=%0t", $time);
        end
    endtask

    task automatic compare_packet();
        bit bad;
        bad = 1'b0;
        check_field("slot_valid_o", 64'(exp_slot_valid_i), 64'(slot_valid_i), bad);
        check_field("pc_o",         exp_pc_i,              pc_i,              bad);
        check_field("unit_o",       64'(exp_unit_i),       64'(unit_i),       bad);
        check_field("w_reg_o",      64'(exp_w_reg_i),      64'(w_reg_i),      bad);
        check_field("w_mem_o",      64'(exp_w_mem_i),      64'(w_mem_i),      bad);
        check_field("reg_need_o",   64'(exp_need_i),       64'(reg_need_i),   bad);
        check_field("use_imm_o",    64'(exp_use_i),        64'(use_imm_i),    bad);
        check_field("r_arfid_o",    64'(exp_r_arfid_i),    64'(r_arfid_i),    bad);
        check_field("w_arfid_o",    64'(exp_w_arfid_i),    64'(w_arfid_i),    bad);
        check_field("data_imm_o",   exp_data_imm_i,        data_imm_i,        bad);
        check_field("addr_imm_o",   exp_addr_imm_i,        addr_imm_i,        bad);
        if (bad) begin
            $display("FAIL test %0d at t=%0t", cnt_o, $time);
            fail_o <= fail_o + 1;
        end else begin
            $display("PASS test %0d at t=%0t", cnt_o, $time);
        end
    endtask

    task automatic report_counts();
        $display("tests seen %0d of %0d, failed %0d", cnt_o, n_vec_i, fail_o);
    endtask

    initial begin
        cnt_o   = 0;
        fail_o  = 0;
        stalled = 1'b0;
        fresh   = 1'b0;
        snap    = '0;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            stalled <= 1'b0;
            fresh   <= 1'b1;
        end else begin
            if (fresh)
                check_reset(); // before any stimulus
            fresh <= 1'b0;
            if (stalled && out_valid_i && cur !== snap) begin
                $display("outputs changed while stalled at t=%0t", $time);
                fail_o <= fail_o + 1;
            end
            stalled <= out_valid_i && !out_ready_i;
            snap    <= cur;
            if (out_valid_i && out_ready_i) begin
                if (cnt_o >= n_vec_i) begin
                    $display("extra packet left the stage at t=%0t", $time);
                    fail_o <= fail_o + 1;
                end else begin
                    compare_packet(); // in vector order
                end
                cnt_o <= cnt_o + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int MAX_VEC = 32;

    logic                                     clk_i;
    logic                                     reset_i;
    logic                                     in_valid_i;
    pipe_pkg::slot_flag_t                     in_mask_i;
    pipe_pkg::slot_word_t                     in_pc_i;
    pipe_pkg::slot_inst_t                     in_inst_i;
    logic                                     in_ready_o;
    logic                                     out_valid_o;
    logic                                     out_ready_i;
    pipe_pkg::slot_flag_t                     slot_valid_o;
    pipe_pkg::slot_word_t                     pc_o;
    isa_pkg::unit_e [pipe_pkg::NUM_SLOTS-1:0] unit_o;
    pipe_pkg::slot_flag_t                     w_reg_o;
    pipe_pkg::slot_flag_t                     w_mem_o;
    pipe_pkg::src_flag_t                      reg_need_o;
    pipe_pkg::src_flag_t                      use_imm_o;
    pipe_pkg::src_arfid_t                     r_arfid_o;
    pipe_pkg::dst_arfid_t                     w_arfid_o;
    pipe_pkg::slot_word_t                     data_imm_o;
    pipe_pkg::slot_word_t                     addr_imm_o;

    // vector storage, one entry per test line
    logic [1:0]  v_mask  [MAX_VEC];
    logic [63:0] v_pc    [MAX_VEC];
    logic [63:0] v_inst  [MAX_VEC];
    int          v_stall [MAX_VEC];
    logic [1:0]  e_sv    [MAX_VEC];
    logic [5:0]  e_unit  [MAX_VEC];
    logic [1:0]  e_wreg  [MAX_VEC];
    logic [1:0]  e_wmem  [MAX_VEC];
    logic [3:0]  e_need  [MAX_VEC];
    logic [3:0]  e_use   [MAX_VEC];
    logic [19:0] e_rid   [MAX_VEC];
    logic [9:0]  e_wid   [MAX_VEC];
    logic [63:0] e_data  [MAX_VEC];
    logic [63:0] e_addr  [MAX_VEC];

    int     n_vec;
    int     max_stall;
    int     mon_cnt;
    int     mon_fail;
    int     idx;
    integer seed;
    bit     loaded;
    bit     started;

    decode_stage dut_i (.*);

    // expected record of the next packet the monitor will see
    assign idx = (mon_cnt < MAX_VEC) ? mon_cnt : 0;

    decode_monitor u_mon (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .out_valid_i     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .in_ready_i      (in_ready_o),
        .slot_valid_i    (slot_valid_o),
        .pc_i            (pc_o),
        .unit_i          (unit_o),
        .w_reg_i         (w_reg_o),
        .w_mem_i         (w_mem_o),
        .reg_need_i      (reg_need_o),
        .use_imm_i       (use_imm_o),
        .r_arfid_i       (r_arfid_o),
        .w_arfid_i       (w_arfid_o),
        .data_imm_i      (data_imm_o),
        .addr_imm_i      (addr_imm_o),
        .n_vec_i         (n_vec),
        .exp_slot_valid_i(e_sv[idx]),
        .exp_pc_i        (v_pc[idx]),
        .exp_unit_i      (e_unit[idx]),
        .exp_w_reg_i     (e_wreg[idx]),
        .exp_w_mem_i     (e_wmem[idx]),
        .exp_need_i      (e_need[idx]),
        .exp_use_i       (e_use[idx]),
        .exp_r_arfid_i   (e_rid[idx]),
        .exp_w_arfid_i   (e_wid[idx]),
        .exp_data_imm_i  (e_data[idx]),
        .exp_addr_imm_i  (e_addr[idx]),
        .cnt_o           (mon_cnt),
        .fail_o          (mon_fail)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        logic [31:0] f [23];
        fd = $fopen("sim/decode_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/decode_vectors.txt, no tests run");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                rc = $fgets(line, fd);
                if (rc == 0 || line.len() < 2 || line[0] == 8'h23)
                    continue; // blank or comment line
                rc = $sscanf(line, "%h %h %h %h %h %d %h %h %h %h %h %h %h %d %d %d %d %d %d %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                             f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                             f[20], f[21], f[22]);
                if (rc != 23)
                    continue;
                v_mask[n_vec]  = f[0][1:0];
                v_pc[n_vec]    = {f[2], f[1]};
                v_inst[n_vec]  = {f[4], f[3]};
                v_stall[n_vec] = int'(f[5]);
                e_sv[n_vec]    = f[6][1:0];
                e_unit[n_vec]  = {f[8][2:0], f[7][2:0]};
                e_wreg[n_vec]  = f[9][1:0];
                e_wmem[n_vec]  = f[10][1:0];
                e_need[n_vec]  = f[11][3:0];
                e_use[n_vec]   = f[12][3:0];
                e_rid[n_vec]   = {f[16][4:0], f[15][4:0], f[14][4:0], f[13][4:0]};
                e_wid[n_vec]   = {f[18][4:0], f[17][4:0]};
                e_data[n_vec]  = {f[20], f[19]};
                e_addr[n_vec]  = {f[22], f[21]};
                if (v_stall[n_vec] > max_stall)
                    max_stall = v_stall[n_vec];
                n_vec++;
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_mask_i   = '0;
        in_pc_i     = '0;
        in_inst_i   = '0;
        out_ready_i = 1'b1;
        seed        = 41;
        n_vec       = 0;
        max_stall   = 0;
        loaded      = 1'b0;
        started     = 1'b0;
        load_vectors();
        loaded = 1'b1;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        started = 1'b1;

        for (int i = 0; i < n_vec; i++) begin
            @(negedge clk_i);
            in_mask_i  = v_mask[i];
            in_pc_i    = v_pc[i];
            in_inst_i  = v_inst[i];
            in_valid_i = 1'b1;
            do @(posedge clk_i); while (in_ready_o !== 1'b1);
            if ($random(seed) % 4 == 0) begin
                @(negedge clk_i);
                in_valid_i = 1'b0; // idle gap
            end
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;

        wait (mon_cnt >= n_vec);
        repeat (2) @(posedge clk_i);
        u_mon.report_counts();
        if (mon_fail == 0 && mon_cnt == n_vec && n_vec > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // rename side back-pressure
    initial begin
        int j;
        wait (started);
        j = 0;
        while (j < n_vec) begin
            @(negedge clk_i);
            if (out_valid_o === 1'b1) begin
                repeat (v_stall[j]) begin
                    out_ready_i = 1'b0;
                    @(negedge clk_i);
                end
                out_ready_i = 1'b1;
                j++;
            end
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = n_vec * (max_stall + 4) + 20;
        repeat (limit) @(posedge clk_i);
        $display("timeout after %0d cycles, %0d of %0d packets seen", limit, mon_cnt, n_vec);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/decode_vectors.txt ====
# mask pc0 pc1 inst0 inst1 stall | slot_valid unit0 unit1 w_reg w_mem need use
# r_arfid0..3 w_arfid0 w_arfid1 (decimal) data_imm0 data_imm1 addr_imm0 addr_imm1 (hex)
3 00001000 00001004 00101483 001120E6 0 3 1 1 3 0 f 0 4 5 7 8 3 6 00000000 00000000 00000000 00000000
3 00001008 0000100c 00148C41 001577DF 2 3 1 1 3 0 f 0 2 3 30 29 1 31 00000000 00000000 00000000 00000000
3 00001010 00001014 00121483 001C1483 0 3 1 2 3 0 f 0 4 5 4 5 3 3 00000000 00000000 00000000 00000000
3 00001018 0000101c 00201483 0010316A 3 3 2 1 3 0 f 0 4 5 11 12 3 10 00000000 00000000 00000000 00000000
3 00001020 00001024 02BFFC83 03A000C5 1 3 1 1 3 0 5 a 4 0 6 0 3 5 FFFFFFFF 00000800 00000000 00000000
3 00001028 0000102c 142468A7 029FFC41 0 3 1 1 3 0 4 a 0 0 2 0 7 1 12345000 000007FF 00000000 00000000
3 00001030 00001034 28BFF083 298040C5 2 3 3 3 1 2 d 0 4 0 6 5 3 0 00000000 00000000 FFFFFFFC 00000010
3 00001038 0000103c 5BFFF883 54001001 3 3 4 4 2 0 3 0 4 3 0 0 0 1 00000000 00000000 FFFFFFF8 00040010
1 00001040 00001044 00101483 FFFFFFFF 1 1 1 0 1 0 3 0 4 5 0 0 3 0 00000000 00000000 00000000 00000000
2 00001048 0000104c 00000000 57FFFFFF 0 2 0 4 2 0 0 0 0 0 0 0 0 1 00000000 00000000 00000000 FFFFFFFC
0 00001050 00001054 0010316A 00101483 0 0 1 1 3 0 f 0 11 12 4 5 10 3 00000000 00000000 00000000 00000000
3 00001058 0000105c 001C1483 0010316A 4 3 2 1 3 0 f 0 4 5 11 12 3 10 00000000 00000000 00000000 00000000

// ==== decode_stage.f ====
source/pipe_pkg.sv
source/isa_pkg.sv
source/fetch_bundle_if.sv
source/decode_ctrl.sv
source/basic_decoder.sv
source/operand_select.sv
source/imm_gen.sv
source/decode_stage.sv
sim/decode_stage_chk.sv
sim/decode_monitor.sv
sim/decode_stage_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the decode stage testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module decode_stage_tb \
		-f decode_stage.f -o decode_stage_tb
	@out="$$(./obj_dir/decode_stage_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
